//--- sample_stream_buffer.f
+incdir+source
source/stream_buffer_pkg.sv
source/sample_packer.sv
source/bulk_ring_store.sv
source/burst_unpacker.sv
source/fill_monitor.sv
source/sample_stream_buffer.sv
test/tb_sample_stream_buffer.sv

//--- source/bulk_ring_store.sv
`timescale 1ns/1ps

`include "stream_buffer_defines.svh"

module bulk_ring_store (
	input logic okClk,
	input logic reset,
	input logic pack_valid,
	input stream_buffer_pkg::burst_t pack_burst,
	input logic store_credit,
	output logic pack_credit,
	output logic store_valid,
	output stream_buffer_pkg::burst_t store_burst,
	output stream_buffer_pkg::sample_count_t ring_samples
);

	localparam int IN_PTR_W = $clog2(`SB_INGRESS_DEPTH);
	localparam int IN_CNT_W = $clog2(`SB_INGRESS_DEPTH + 1);
	localparam int CRD_W = $clog2(`SB_OUT_DEPTH + 1);
	localparam int RING_SIZE = 1 << `SB_RING_LOG2;

	////////////////////////////////////////
	// ingress queue
	////////////////////////////////////////
	stream_buffer_pkg::burst_t in_mem [`SB_INGRESS_DEPTH];
	logic [IN_PTR_W-1:0] in_wr;
	logic [IN_PTR_W-1:0] in_rd;
	logic [IN_CNT_W-1:0] in_count;

	////////////////////////////////////////
	// ring RAM and pointers
	////////////////////////////////////////
	stream_buffer_pkg::burst_t ram [RING_SIZE];
	// top bit is the wrap bit
	logic [`SB_RING_LOG2:0] wr_ptr;
	logic [`SB_RING_LOG2:0] rd_ptr;
	logic [`SB_RING_LOG2:0] ring_level;
	// slots free in the unpacker queue
	logic [CRD_W-1:0] credits;
	stream_buffer_pkg::port_op_t port_op;
	stream_buffer_pkg::ring_addr_t port_addr;

	// unread bursts, goes wrong only after a lap
	assign ring_level = wr_ptr - rd_ptr;

	// writes win the port, reads fill the idle cycles
	always_comb begin
		if (in_count != '0) begin
			port_op = stream_buffer_pkg::PORT_WRITE;
		end else if ((ring_level != '0) && (credits != '0)) begin
			port_op = stream_buffer_pkg::PORT_READ;
		end else begin
			port_op = stream_buffer_pkg::PORT_IDLE;
		end
	end

	assign port_addr = (port_op == stream_buffer_pkg::PORT_WRITE)
		? wr_ptr[`SB_RING_LOG2-1:0] : rd_ptr[`SB_RING_LOG2-1:0];

	// ingress slot frees on the cycle its burst goes into the RAM
	assign pack_credit = (port_op == stream_buffer_pkg::PORT_WRITE);

	always_ff @(posedge okClk) begin
		if (reset) begin
			in_wr <= '0;
			in_rd <= '0;
			in_count <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			credits <= CRD_W'(`SB_OUT_DEPTH);
			store_valid <= 1'b0;
		end else begin
			if (pack_valid) begin
				in_wr <= in_wr + 1'b1;
			end
			if (port_op == stream_buffer_pkg::PORT_WRITE) begin
				in_rd <= in_rd + 1'b1;
				// no check against rd_ptr, old data gets lapped
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (port_op == stream_buffer_pkg::PORT_READ) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			in_count <= in_count + IN_CNT_W'(pack_valid) - IN_CNT_W'(pack_credit);
			// credit spent when the read is issued
			credits <= credits - CRD_W'(port_op == stream_buffer_pkg::PORT_READ)
				+ CRD_W'(store_credit);
			store_valid <= (port_op == stream_buffer_pkg::PORT_READ);
		end
	end

	always_ff @(posedge okClk) begin
		if (pack_valid) begin
			in_mem[in_wr] <= pack_burst;
		end
	end

	// single port, one access per cycle
	always_ff @(posedge okClk) begin
		case (port_op)
			stream_buffer_pkg::PORT_WRITE: ram[port_addr] <= in_mem[in_rd];
			stream_buffer_pkg::PORT_READ: store_burst <= ram[port_addr];
			default: ;
		endcase
	end

	// burst in flight to the unpacker counted here
	stream_buffer_pkg::sample_count_t ring_bursts;

	assign ring_bursts = stream_buffer_pkg::sample_count_t'(ring_level)
		+ stream_buffer_pkg::sample_count_t'(in_count)
		+ stream_buffer_pkg::sample_count_t'(store_valid);
	assign ring_samples = ring_bursts * `SB_SAMPLES_PER_BURST;

endmodule

//--- source/burst_unpacker.sv
`timescale 1ns/1ps

`include "stream_buffer_defines.svh"

module burst_unpacker (
	input logic okClk,
	input logic reset,
	input logic store_valid,
	input stream_buffer_pkg::burst_t store_burst,
	input logic read_en,
	output logic store_credit,
	output stream_buffer_pkg::word_t read_data,
	output stream_buffer_pkg::word_count_t out_words
);

	localparam int WORDS_PER_BURST = `SB_SAMPLE_W * `SB_SAMPLES_PER_BURST / `SB_WORD_W;
	localparam int IDX_W = $clog2(WORDS_PER_BURST);
	localparam int PTR_W = $clog2(`SB_OUT_DEPTH);
	localparam int CNT_W = $clog2(`SB_OUT_DEPTH + 1);

	////////////////////////////////////////
	// output burst queue
	////////////////////////////////////////
	stream_buffer_pkg::burst_t out_mem [`SB_OUT_DEPTH];
	logic [PTR_W-1:0] out_wr;
	logic [PTR_W-1:0] out_rd;
	logic [CNT_W-1:0] out_count;

	// next word to hand out from the head burst
	logic [IDX_W-1:0] word_idx;
	logic take;
	logic pop;
	stream_buffer_pkg::word_t head_word;

	// reads on an empty queue are ignored
	assign take = read_en && (out_count != '0);
	assign pop = take && (word_idx == IDX_W'(WORDS_PER_BURST - 1));

	// word k holds samples 2k and 2k+1
	assign head_word = out_mem[out_rd][word_idx*`SB_WORD_W +: `SB_WORD_W];

	always_ff @(posedge okClk) begin
		if (reset) begin
			out_wr <= '0;
			out_rd <= '0;
			out_count <= '0;
			word_idx <= '0;
			store_credit <= 1'b0;
		end else begin
			if (store_valid) begin
				out_wr <= out_wr + 1'b1;
			end
			if (take) begin
				word_idx <= word_idx + 1'b1;
			end
			if (pop) begin
				out_rd <= out_rd + 1'b1;
			end
			out_count <= out_count + CNT_W'(store_valid) - CNT_W'(pop);
			// slot freed by the last word of the head burst
			store_credit <= pop;
		end
	end

	always_ff @(posedge okClk) begin
		if (store_valid) begin
			out_mem[out_wr] <= store_burst;
		end
	end

	////////////////////////////////////////
	// host read port
	////////////////////////////////////////
	// on underflow the last word stays on the port
	always_ff @(posedge okClk) begin
		if (reset) begin
			read_data <= '0;
		end else if (take) begin
			read_data <= head_word;
		end
	end

	// whole bursts held minus words already taken from the head
	assign out_words = stream_buffer_pkg::word_count_t'(out_count) * WORDS_PER_BURST
		- stream_buffer_pkg::word_count_t'(word_idx);

endmodule

//--- source/fill_monitor.sv
`timescale 1ns/1ps

module fill_monitor (
	input logic okClk,
	input logic reset,
	input stream_buffer_pkg::sample_count_t packer_samples,
	input stream_buffer_pkg::sample_count_t ring_samples,
	input stream_buffer_pkg::word_count_t out_words,
	input stream_buffer_pkg::word_count_t block_size,
	output stream_buffer_pkg::sample_count_t num_words,
	output logic out_ready
);

	////////////////////////////////////////
	// total occupancy
	////////////////////////////////////////
	// output words carry two samples each
	stream_buffer_pkg::sample_count_t out_samples;
	stream_buffer_pkg::sample_count_t total;

	assign out_samples = stream_buffer_pkg::sample_count_t'(out_words) << 1;
	assign total = packer_samples + ring_samples + out_samples;

	always_ff @(posedge okClk) begin
		if (reset) begin
			num_words <= '0;
		end else begin
			num_words <= total;
		end
	end

	////////////////////////////////////////
	// block ready flag
	////////////////////////////////////////
	// host may start a block transfer once the output queue covers it
	always_ff @(posedge okClk) begin
		if (reset) begin
			out_ready <= 1'b0;
		end else begin
			out_ready <= (out_words >= block_size);
		end
	end

endmodule

//--- source/sample_packer.sv
`timescale 1ns/1ps

`include "stream_buffer_defines.svh"

module sample_packer (
	input logic okClk,
	input logic reset,
	input logic write_en,
	input stream_buffer_pkg::sample_t write_data,
	input logic pack_credit,
	output logic pack_valid,
	output stream_buffer_pkg::burst_t pack_burst,
	output stream_buffer_pkg::sample_count_t packer_samples
);

	localparam int POS_W = $clog2(`SB_SAMPLES_PER_BURST);
	localparam int PTR_W = $clog2(`SB_PACK_DEPTH);
	localparam int CNT_W = $clog2(`SB_PACK_DEPTH + 1);
	localparam int CRD_W = $clog2(`SB_INGRESS_DEPTH + 1);
	localparam int BURST_W = `SB_SAMPLE_W * `SB_SAMPLES_PER_BURST;

	////////////////////////////////////////
	// partial burst assembly
	////////////////////////////////////////
	// position of the next sample inside the partial burst
	logic [POS_W-1:0] pos;
	stream_buffer_pkg::burst_t partial;
	// new sample enters at the top, earlier ones move toward bit 0
	stream_buffer_pkg::burst_t shifted;
	logic burst_done;

	assign shifted = {write_data, partial[BURST_W-1:`SB_SAMPLE_W]};
	assign burst_done = write_en && (pos == POS_W'(`SB_SAMPLES_PER_BURST - 1));

	always_ff @(posedge okClk) begin
		if (reset) begin
			pos <= '0;
		end else if (write_en) begin
			pos <= pos + 1'b1;
		end
	end

	always_ff @(posedge okClk) begin
		if (write_en) begin
			partial <= shifted;
		end
	end

	////////////////////////////////////////
	// burst queue and credit sender
	////////////////////////////////////////
	stream_buffer_pkg::burst_t q_mem [`SB_PACK_DEPTH];
	logic [PTR_W-1:0] q_wr;
	logic [PTR_W-1:0] q_rd;
	logic [CNT_W-1:0] q_count;
	// slots free in the store ingress queue
	logic [CRD_W-1:0] credits;
	logic send;

	// one burst per cycle at most, only with a credit in hand
	assign send = (q_count != '0) && (credits != '0);

	always_ff @(posedge okClk) begin
		if (reset) begin
			q_wr <= '0;
			q_rd <= '0;
			q_count <= '0;
			credits <= CRD_W'(`SB_INGRESS_DEPTH);
			pack_valid <= 1'b0;
		end else begin
			pack_valid <= send;
			if (burst_done) begin
				q_wr <= q_wr + 1'b1;
			end
			if (send) begin
				q_rd <= q_rd + 1'b1;
			end
			q_count <= q_count + CNT_W'(burst_done) - CNT_W'(send);
			credits <= credits - CRD_W'(send) + CRD_W'(pack_credit);
		end
	end

	always_ff @(posedge okClk) begin
		if (burst_done) begin
			q_mem[q_wr] <= shifted;
		end
		if (send) begin
			pack_burst <= q_mem[q_rd];
		end
	end

	// burst on the link still belongs to this stage for counting
	assign packer_samples = stream_buffer_pkg::sample_count_t'(pos)
		+ (stream_buffer_pkg::sample_count_t'(q_count)
		+ stream_buffer_pkg::sample_count_t'(pack_valid)) * `SB_SAMPLES_PER_BURST;

endmodule

//--- source/sample_stream_buffer.sv
`timescale 1ns/1ps

module sample_stream_buffer (
	input logic okClk,
	input logic reset,
	input logic write_en,
	input stream_buffer_pkg::sample_t write_data,
	input logic read_en,
	input stream_buffer_pkg::word_count_t block_size,
	output stream_buffer_pkg::word_t read_data,
	output logic out_ready,
	output stream_buffer_pkg::sample_count_t num_words
);

	////////////////////////////////////////
	// credit links between stages
	////////////////////////////////////////
	// packer to store
	logic pack_valid;
	stream_buffer_pkg::burst_t pack_burst;
	logic pack_credit;
	// store to unpacker
	logic store_valid;
	stream_buffer_pkg::burst_t store_burst;
	logic store_credit;

	// stage occupancies for the monitor
	stream_buffer_pkg::sample_count_t packer_samples;
	stream_buffer_pkg::sample_count_t ring_samples;
	stream_buffer_pkg::word_count_t out_words;

	// 16-bit samples into 128-bit bursts
	sample_packer u_packer (
		.okClk(okClk),
		.reset(reset),
		.write_en(write_en),
		.write_data(write_data),
		.pack_credit(pack_credit),
		.pack_valid(pack_valid),
		.pack_burst(pack_burst),
		.packer_samples(packer_samples)
	);

	// bulk ring, laps on overflow
	bulk_ring_store u_store (
		.okClk(okClk),
		.reset(reset),
		.pack_valid(pack_valid),
		.pack_burst(pack_burst),
		.store_credit(store_credit),
		.pack_credit(pack_credit),
		.store_valid(store_valid),
		.store_burst(store_burst),
		.ring_samples(ring_samples)
	);

	// bursts out as 32-bit host words
	burst_unpacker u_unpacker (
		.okClk(okClk),
		.reset(reset),
		.store_valid(store_valid),
		.store_burst(store_burst),
		.read_en(read_en),
		.store_credit(store_credit),
		.read_data(read_data),
		.out_words(out_words)
	);

	fill_monitor u_monitor (
		.okClk(okClk),
		.reset(reset),
		.packer_samples(packer_samples),
		.ring_samples(ring_samples),
		.out_words(out_words),
		.block_size(block_size),
		.num_words(num_words),
		.out_ready(out_ready)
	);

endmodule

//--- source/stream_buffer_defines.svh
`ifndef STREAM_BUFFER_DEFINES_SVH
`define STREAM_BUFFER_DEFINES_SVH

////////////////////////////////////////
// sample and word sizes
////////////////////////////////////////
`define SB_SAMPLE_W 16
`define SB_WORD_W 32
`define SB_SAMPLES_PER_BURST 8

////////////////////////////////////////
// queue and ring depths
////////////////////////////////////////
`define SB_PACK_DEPTH 4
`define SB_INGRESS_DEPTH 2
`define SB_OUT_DEPTH 4
// ring holds 2**6 = 64 bursts
`define SB_RING_LOG2 6
`define SB_COUNT_W 32

`endif

//--- source/stream_buffer_pkg.sv
`include "stream_buffer_defines.svh"

package stream_buffer_pkg;

	////////////////////////////////////////
	// data types
	////////////////////////////////////////
	// one input sample from the acquisition side
	typedef logic [`SB_SAMPLE_W-1:0] sample_t;
	// one host word, two samples side by side
	typedef logic [`SB_WORD_W-1:0] word_t;
	// one burst, sample 0 in the low bits
	typedef logic [`SB_SAMPLE_W*`SB_SAMPLES_PER_BURST-1:0] burst_t;
	// burst index into the ring RAM
	typedef logic [`SB_RING_LOG2-1:0] ring_addr_t;
	// occupancy in 16-bit samples
	typedef logic [`SB_COUNT_W-1:0] sample_count_t;
	// block size and output level in 32-bit words
	typedef logic [`SB_COUNT_W-1:0] word_count_t;

	// use of the ring RAM port in a given cycle
	typedef enum logic [1:0] {
		PORT_IDLE,
		PORT_WRITE,
		PORT_READ
	} port_op_t;

endpackage

//--- test/stream_buffer_input.txt
# columns: test name, operation, operand
# write/read take counts, settle takes cycles, block/level/ready take values, reset takes 0
setup        block   4
setup        level   0
order        write   32
order        settle  16
order        ready   1
order        read    6
order        settle  16
occupancy    level   20
occupancy    block   12
occupancy    settle  4
occupancy    ready   0
blocksize    block   10
blocksize    settle  4
blocksize    ready   1
underflow    read    14
underflow    settle  16
underflow    level   0
underflow    ready   0
backpressure write   200
backpressure settle  16
backpressure level   200
backpressure ready   1
backpressure read    100
backpressure settle  16
backpressure level   0
midreset     write   13
midreset     reset   0
midreset     level   0
midreset     ready   0
after_reset  write   24
after_reset  settle  16
after_reset  read    12
after_reset  settle  16
after_reset  level   0
after_reset  ready   0

//--- test/tb_sample_stream_buffer.sv
`timescale 1ns/1ps

`include "stream_buffer_defines.svh"

module tb_sample_stream_buffer;

	localparam int CLK_NS = 4;
	localparam int SETTLE_MARGIN = 14;
	localparam int SPB = `SB_SAMPLES_PER_BURST;
	localparam int WPB = `SB_SAMPLE_W * `SB_SAMPLES_PER_BURST / `SB_WORD_W;

	logic okClk;
	logic reset;
	logic write_en;
	stream_buffer_pkg::sample_t write_data;
	logic read_en;
	stream_buffer_pkg::word_count_t block_size;
	stream_buffer_pkg::word_t read_data;
	logic out_ready;
	stream_buffer_pkg::sample_count_t num_words;

	// parsed test list
	string t_name [$];
	string t_op [$];
	int t_val [$];
	logic list_loaded;
	longint limit_ns;

	// reference model of the samples not yet read in write order
	stream_buffer_pkg::sample_t model_q [$];
	int written;
	int taken;
	logic [31:0] last_word;
	integer seed;

	int errors;
	int checks;

	sample_stream_buffer uut (
		.okClk(okClk),
		.reset(reset),
		.write_en(write_en),
		.write_data(write_data),
		.read_en(read_en),
		.block_size(block_size),
		.read_data(read_data),
		.out_ready(out_ready),
		.num_words(num_words)
	);

	initial begin
		okClk = 1'b0;
		forever #(CLK_NS / 2) okClk = ~okClk;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	// only whole bursts ever reach the read port
	function automatic int readable_words();
		return (written / SPB) * WPB;
	endfunction

	// words sitting in the output queue once settled
	function automatic int held_words();
		int bursts;
		bursts = written / SPB - taken / WPB;
		if (bursts > `SB_OUT_DEPTH) begin
			bursts = `SB_OUT_DEPTH;
		end
		if (bursts == 0) begin
			return 0;
		end
		return bursts * WPB - taken % WPB;
	endfunction

	function automatic int model_level();
		return written - 2 * taken;
	endfunction

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected %0h, actual %0h", test_name, expected, actual);
		end
	endtask

	////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////
	task automatic apply_reset();
		@(posedge okClk);
		reset <= 1'b1;
		write_en <= 1'b0;
		read_en <= 1'b0;
		repeat (3) @(posedge okClk);
		reset <= 1'b0;
		// model empties along with the DUT
		model_q.delete();
		written = 0;
		taken = 0;
		last_word = '0;
	endtask

	task automatic write_samples(input int n);
		stream_buffer_pkg::sample_t s;
		int i;
		for (i = 0; i < n; i++) begin
			s = $random(seed);
			@(posedge okClk);
			write_en <= 1'b1;
			write_data <= s;
			model_q.push_back(s);
			written++;
		end
		@(posedge okClk);
		write_en <= 1'b0;
	endtask

	task automatic read_words(input string test_name, input int n);
		logic [31:0] expect_q [$];
		stream_buffer_pkg::sample_t lo;
		stream_buffer_pkg::sample_t hi;
		int i;
		// expected words first with the low sample in the low half
		for (i = 0; i < n; i++) begin
			if (taken < readable_words()) begin
				lo = model_q.pop_front();
				hi = model_q.pop_front();
				last_word = {hi, lo};
				taken++;
			end
			// past the data the port repeats its last word
			expect_q.push_back(last_word);
		end
		// back to back reads with each word checked a cycle after its read
		for (i = 0; i <= n; i++) begin
			@(posedge okClk);
			read_en <= (i < n);
			@(negedge okClk);
			if (i > 0) begin
				check_value(test_name, expect_q[i-1], read_data);
			end
		end
	endtask

	task automatic run_line(input string nm, input string opc, input int val);
		if (opc == "write") begin
			write_samples(val);
		end else if (opc == "read") begin
			read_words(nm, val);
		end else if (opc == "block") begin
			@(posedge okClk);
			block_size <= val;
		end else if (opc == "settle") begin
			repeat (val) @(posedge okClk);
		end else if (opc == "level") begin
			@(negedge okClk);
			check_value(nm, val, num_words);
			check_value({nm, " model level"}, val, model_level());
		end else if (opc == "ready") begin
			@(negedge okClk);
			check_value(nm, val, out_ready);
			// flag is set once the held words cover the block
			check_value({nm, " model ready"}, val, held_words() >= int'(block_size));
		end else if (opc == "reset") begin
			// the level includes any partial burst right before it is dropped
			repeat (SETTLE_MARGIN) @(posedge okClk);
			@(negedge okClk);
			check_value({nm, " before reset"}, model_level(), num_words);
			apply_reset();
		end else begin
			errors++;
			$display("unknown operation %s in test %s", opc, nm);
		end
	endtask

	////////////////////////////////////////
	// test list reader
	////////////////////////////////////////
	task automatic load_list();
		integer fd;
		reg [8*128-1:0] line_buf;
		string nm;
		string opc;
		int val;
		int cnt;
		longint cycles;
		// reset plus a margin even for an empty list
		cycles = 3 + SETTLE_MARGIN;
		fd = $fopen("test/stream_buffer_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the test list test/stream_buffer_input.txt");
		end else begin
			while (!$feof(fd)) begin
				line_buf = '0;
				nm = "";
				cnt = $fgets(line_buf, fd);
				cnt = $sscanf(line_buf, "%s %s %d", nm, opc, val);
				// comment lines open with #
				if (cnt == 3 && nm.substr(0, 0) != "#") begin
					t_name.push_back(nm);
					t_op.push_back(opc);
					t_val.push_back(val);
					if (opc == "write" || opc == "read" || opc == "settle") begin
						cycles += val;
					end
					cycles += SETTLE_MARGIN;
				end
			end
			$fclose(fd);
		end
		// twice the expected run length
		limit_ns = cycles * CLK_NS * 2;
		list_loaded = 1'b1;
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////
	initial begin
		reset = 1'b1;
		write_en = 1'b0;
		write_data = '0;
		read_en = 1'b0;
		block_size = '0;
		seed = 32'hd154_1af5;
		errors = 0;
		checks = 0;
		list_loaded = 1'b0;
		load_list();
		apply_reset();
		for (int i = 0; i < t_name.size(); i++) begin
			run_line(t_name[i], t_op[i], t_val[i]);
		end
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		wait (list_loaded === 1'b1);
		#(limit_ns);
		$display("timeout: the test list did not finish within %0d ns", limit_ns);
		$display("Done: errors found");
		$finish;
	end

endmodule
